//--- hw/scope_stream_pkg.sv
package scope_stream_pkg;

  // ADC sample width
  localparam int unsigned SMP_W = 16;

  // decimation counter width that the accumulator is sized for
  localparam int unsigned ACC_DCW = 17;

  // one signed ADC sample
  typedef logic signed [SMP_W-1:0] sample_t;

  // output beat, sample plus end-of-acquisition flag
  typedef struct packed {
    sample_t data;
    logic    last;
  } out_beat_t;

  // decimator sum, wide enough for a full group
  typedef logic signed [SMP_W+ACC_DCW-1:0] acc_t;

endpackage

//--- hw/scope_reg_pkg.sv
package scope_reg_pkg;

  // register bus widths
  localparam int unsigned BUS_AW = 7;
  localparam int unsigned BUS_DW = 32;

  // pre/post trigger counter width
  localparam int unsigned CNT_W = 32;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  // control pulses on write, status on read
  localparam logic [BUS_AW-1:0] REG_CTL     = 7'h00;
  // continuous, automatic, edge enable
  localparam logic [BUS_AW-1:0] REG_MODE    = 7'h04;
  // external event masks
  localparam logic [BUS_AW-1:0] REG_MSK_STR = 7'h10;
  localparam logic [BUS_AW-1:0] REG_MSK_STP = 7'h14;
  localparam logic [BUS_AW-1:0] REG_MSK_TRG = 7'h18;
  // configured and current pre/post counts
  localparam logic [BUS_AW-1:0] REG_PRE     = 7'h20;
  localparam logic [BUS_AW-1:0] REG_PST     = 7'h24;
  localparam logic [BUS_AW-1:0] REG_STS_PRE = 7'h28;
  localparam logic [BUS_AW-1:0] REG_STS_PST = 7'h2c;
  // edge trigger levels and polarity
  localparam logic [BUS_AW-1:0] REG_POS     = 7'h30;
  localparam logic [BUS_AW-1:0] REG_NEG     = 7'h34;
  localparam logic [BUS_AW-1:0] REG_EDG     = 7'h38;
  // decimation
  localparam logic [BUS_AW-1:0] REG_DEC     = 7'h40;
  localparam logic [BUS_AW-1:0] REG_SHR     = 7'h44;
  localparam logic [BUS_AW-1:0] REG_AVG     = 7'h48;

endpackage

//--- hw/sample_stream_if.sv
`timescale 1ns/100ps

// valid/ready stream, payload type chosen per instance
interface sample_stream_if #(
  parameter type T = scope_stream_pkg::sample_t
) ();

  // handshake, transfer when both high on an edge
  logic valid;
  logic ready;

  // payload, held together with valid until taken
  T     data;

  // producer side
  modport src (output valid, output data, input ready);
  // consumer side
  modport dst (input valid, input data, output ready);
  // passive observer
  modport mon (input valid, input data, input ready);

endinterface

//--- hw/scope_ctl_if.sv
`timescale 1ns/100ps

// register file <-> acquisition controller
interface scope_ctl_if #(
  parameter int unsigned EW = 4,
  parameter int unsigned CW = 32
) ();

  // one-cycle control pulses
  logic          ctl_rst;
  logic          sw_str;
  logic          sw_stp;
  logic          sw_trg;
  // mode bits
  logic          cfg_con;
  logic          cfg_aut;
  logic          cfg_edg_en;
  // external event masks
  logic [EW-1:0] cfg_str;
  logic [EW-1:0] cfg_stp;
  logic [EW-1:0] cfg_trg;
  // pre/post trigger counts
  logic [CW-1:0] cfg_pre;
  logic [CW-1:0] cfg_pst;
  // status back from the FSM
  logic          sts_str;
  logic          sts_stp;
  logic          sts_trg;
  logic [CW-1:0] sts_pre;
  logic [CW-1:0] sts_pst;

  modport regs (
    output ctl_rst, sw_str, sw_stp, sw_trg,
    output cfg_con, cfg_aut, cfg_edg_en, cfg_str, cfg_stp, cfg_trg, cfg_pre, cfg_pst,
    input  sts_str, sts_stp, sts_trg, sts_pre, sts_pst
  );

  modport acq (
    input  ctl_rst, sw_str, sw_stp, sw_trg,
    input  cfg_con, cfg_aut, cfg_edg_en, cfg_str, cfg_stp, cfg_trg, cfg_pre, cfg_pst,
    output sts_str, sts_stp, sts_trg, sts_pre, sts_pst
  );

endinterface

//--- hw/scope_regs.sv
`timescale 1ns/100ps

module scope_regs #(
  parameter int unsigned EW  = 4,
  parameter int unsigned CW  = 32,
  parameter int unsigned DCW = 17,
  parameter int unsigned DSW = 4
) (
  input  logic                              bus,
  input  logic                              rst,
  // register bus
  input  logic                              wen,
  input  logic                              ren,
  input  logic [scope_reg_pkg::BUS_AW-1:0]  addr,
  input  logic [scope_reg_pkg::BUS_DW-1:0]  wdata,
  output logic [scope_reg_pkg::BUS_DW-1:0]  rdata,
  output logic                              ack,
  // acquisition control
  scope_ctl_if.regs                         ctl,
  // decimator config
  output logic [DCW-1:0]                    cfg_dec,
  output logic [DSW-1:0]                    cfg_shr,
  output logic                              cfg_avg,
  // edge trigger config
  output scope_stream_pkg::sample_t         cfg_pos,
  output scope_stream_pkg::sample_t         cfg_neg,
  output logic                              cfg_edg
);

  import scope_reg_pkg::*;
  import scope_stream_pkg::*;

  logic              ctl_wr;
  logic [BUS_DW-1:0] rd_mux;

  assign ctl_wr = wen && (addr == REG_CTL);

  // one cycle ack per access
  always_ff @(posedge bus) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= wen || ren;
    end
  end

  ////////////////////////////////////////////////////////////
  // configuration writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      ctl.cfg_con    <= 1'b0;
      ctl.cfg_aut    <= 1'b0;
      ctl.cfg_edg_en <= 1'b0;
      ctl.cfg_str    <= '0;
      ctl.cfg_stp    <= '0;
      ctl.cfg_trg    <= '0;
      ctl.cfg_pre    <= '0;
      ctl.cfg_pst    <= '0;
      cfg_pos        <= '0;
      cfg_neg        <= '0;
      cfg_edg        <= 1'b0;
      cfg_dec        <= '0;
      cfg_shr        <= '0;
      cfg_avg        <= 1'b0;
    end else if (wen) begin
      case (addr)
        REG_MODE: begin
          ctl.cfg_con    <= wdata[0];
          ctl.cfg_aut    <= wdata[1];
          ctl.cfg_edg_en <= wdata[2];
        end
        REG_MSK_STR: ctl.cfg_str <= wdata[EW-1:0];
        REG_MSK_STP: ctl.cfg_stp <= wdata[EW-1:0];
        REG_MSK_TRG: ctl.cfg_trg <= wdata[EW-1:0];
        REG_PRE:     ctl.cfg_pre <= wdata[CW-1:0];
        REG_PST:     ctl.cfg_pst <= wdata[CW-1:0];
        REG_POS:     cfg_pos     <= wdata[SMP_W-1:0];
        REG_NEG:     cfg_neg     <= wdata[SMP_W-1:0];
        REG_EDG:     cfg_edg     <= wdata[0];
        REG_DEC:     cfg_dec     <= wdata[DCW-1:0];
        REG_SHR:     cfg_shr     <= wdata[DSW-1:0];
        REG_AVG:     cfg_avg     <= wdata[0];
        default: ;
      endcase
    end
  end

  // control pulses, high for the cycle after the write
  always_ff @(posedge bus) begin
    if (rst) begin
      ctl.ctl_rst <= 1'b0;
      ctl.sw_str  <= 1'b0;
      ctl.sw_stp  <= 1'b0;
      ctl.sw_trg  <= 1'b0;
    end else begin
      ctl.ctl_rst <= ctl_wr && wdata[0];
      ctl.sw_str  <= ctl_wr && wdata[1];
      ctl.sw_stp  <= ctl_wr && wdata[2];
      ctl.sw_trg  <= ctl_wr && wdata[3];
    end
  end

  ////////////////////////////////////////////////////////////
  // read back
  ////////////////////////////////////////////////////////////

  // fields zero extended to bus width
  always_comb begin
    case (addr)
      REG_CTL:     rd_mux = BUS_DW'({ctl.sts_trg, ctl.sts_stp, ctl.sts_str, 1'b0});
      REG_MODE:    rd_mux = BUS_DW'({ctl.cfg_edg_en, ctl.cfg_aut, ctl.cfg_con});
      REG_MSK_STR: rd_mux = BUS_DW'(ctl.cfg_str);
      REG_MSK_STP: rd_mux = BUS_DW'(ctl.cfg_stp);
      REG_MSK_TRG: rd_mux = BUS_DW'(ctl.cfg_trg);
      REG_PRE:     rd_mux = BUS_DW'(ctl.cfg_pre);
      REG_PST:     rd_mux = BUS_DW'(ctl.cfg_pst);
      REG_STS_PRE: rd_mux = BUS_DW'(ctl.sts_pre);
      REG_STS_PST: rd_mux = BUS_DW'(ctl.sts_pst);
      REG_POS:     rd_mux = {{(BUS_DW-SMP_W){1'b0}}, cfg_pos};
      REG_NEG:     rd_mux = {{(BUS_DW-SMP_W){1'b0}}, cfg_neg};
      REG_EDG:     rd_mux = BUS_DW'(cfg_edg);
      REG_DEC:     rd_mux = BUS_DW'(cfg_dec);
      REG_SHR:     rd_mux = BUS_DW'(cfg_shr);
      REG_AVG:     rd_mux = BUS_DW'(cfg_avg);
      default:     rd_mux = '0;
    endcase
  end

  // data lands together with ack
  always_ff @(posedge bus) begin
    if (ren) begin
      rdata <= rd_mux;
    end
  end

endmodule

//--- hw/scope_decimator.sv
`timescale 1ns/100ps

module scope_decimator #(
  parameter int unsigned DCW = 17,
  parameter int unsigned DSW = 4
) (
  input  logic           bus,
  input  logic           rst,
  input  logic           ctl_rst,
  input  logic [DCW-1:0] cfg_dec,
  input  logic [DSW-1:0] cfg_shr,
  input  logic           cfg_avg,
  sample_stream_if.dst   sti,
  sample_stream_if.src   sto
);

  import scope_stream_pkg::*;

  logic           run;
  logic           xfer;
  logic           grp_end;
  logic [DCW-1:0] dec_n;
  logic [DCW-1:0] cnt;
  acc_t           acc;
  acc_t           sum;
  acc_t           avg;

  // factor 0 behaves as 1
  assign dec_n   = (cfg_dec == '0) ? DCW'(1) : cfg_dec;
  assign grp_end = (cnt >= dec_n - DCW'(1));

  // running sum including the current sample
  assign sum = acc + acc_t'(sti.data);
  assign avg = sum >>> cfg_shr;

  // stall input while a result waits downstream
  assign sti.ready = run && !sto.valid;
  assign xfer      = sti.valid && sti.ready;

  always_ff @(posedge bus) begin
    if (rst) begin
      run       <= 1'b0;
      sto.valid <= 1'b0;
      cnt       <= '0;
      acc       <= '0;
    end else begin
      run <= 1'b1;
      if (sto.valid && sto.ready) begin
        sto.valid <= 1'b0;
      end
      if (ctl_rst) begin
        cnt <= '0;
        acc <= '0;
      end else if (xfer) begin
        if (grp_end) begin
          cnt       <= '0;
          acc       <= '0;
          sto.valid <= 1'b1;
        end else begin
          cnt <= cnt + DCW'(1);
          acc <= sum;
        end
      end
    end
  end

  // last sample of the group, or the shifted sum truncated to 16 bits
  always_ff @(posedge bus) begin
    if (xfer && grp_end) begin
      sto.data <= cfg_avg ? sample_t'(avg) : sti.data;
    end
  end

  a_out_hold: assert property (@(posedge bus) disable iff (rst)
    sto.valid && !sto.ready |=> sto.valid && $stable(sto.data));

endmodule

//--- hw/scope_edge_trigger.sv
`timescale 1ns/100ps

module scope_edge_trigger (
  input  logic                      bus,
  input  logic                      rst,
  input  logic                      ctl_rst,
  input  scope_stream_pkg::sample_t cfg_pos,
  input  scope_stream_pkg::sample_t cfg_neg,
  input  logic                      cfg_edg,
  sample_stream_if.mon              mon,
  output logic                      evn_edg
);

  import scope_stream_pkg::*;

  logic    xfer;
  logic    armed;
  logic    arm_hit;
  logic    fire;
  sample_t smp;

  assign xfer = mon.valid && mon.ready;
  assign smp  = mon.data;

  // cfg_edg 0 is rising, arm low then fire high
  // cfg_edg 1 mirrors it
  always_comb begin
    if (!cfg_edg) begin
      arm_hit = (smp <= cfg_neg);
      fire    = armed && (smp >= cfg_pos);
    end else begin
      arm_hit = (smp >= cfg_pos);
      fire    = armed && (smp <= cfg_neg);
    end
  end

  // hysteresis state, only moved by transfers
  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      armed   <= 1'b0;
      evn_edg <= 1'b0;
    end else begin
      evn_edg <= xfer && fire;
      if (xfer) begin
        if (fire) begin
          armed <= 1'b0;
        end else if (arm_hit) begin
          armed <= 1'b1;
        end
      end
    end
  end

endmodule

//--- hw/scope_acq_counter.sv
`timescale 1ns/100ps

module scope_acq_counter #(
  parameter int unsigned CW = 32
) (
  input  logic          bus,
  input  logic          rst,
  input  logic          clr,
  input  logic          inc,
  input  logic [CW-1:0] target,
  output logic [CW-1:0] count,
  output logic          reached
);

  // saturating count, pulled back if target drops below it
  always_ff @(posedge bus) begin
    if (rst || clr) begin
      count <= '0;
    end else if (count > target) begin
      count <= target;
    end else if (inc && (count != target)) begin
      count <= count + CW'(1);
    end
  end

  // at target by the end of this cycle
  assign reached = (count >= target) || (inc && (count + CW'(1) == target));

  a_cnt_sat: assert property (@(posedge bus) disable iff (rst)
    $stable(target) |-> count <= target);

endmodule

//--- hw/scope_acq_fsm.sv
`timescale 1ns/100ps

module scope_acq_fsm #(
  parameter int unsigned EW = 4,
  parameter int unsigned CW = 32
) (
  input  logic          bus,
  input  logic          rst,
  scope_ctl_if.acq      ctl,
  input  logic [EW-1:0] evn_ext,
  input  logic          evn_edg,
  sample_stream_if.dst  sti,
  sample_stream_if.src  sto,
  output logic          evn_lst
);

  import scope_stream_pkg::*;

  typedef enum logic [1:0] {IDLE, PRE, ARM, POST} state_t;

  state_t state;
  state_t state_go;
  logic   evn_str;
  logic   evn_stp;
  logic   evn_trg;
  logic   xfer;
  logic   post_now;
  logic   lst;
  logic   done;
  logic   cnt_clr;
  logic   pre_rch;
  logic   pst_rch;

  ////////////////////////////////////////////////////////////
  // events
  ////////////////////////////////////////////////////////////

  assign evn_str = ctl.sw_str || |(evn_ext & ctl.cfg_str);
  assign evn_stp = ctl.sw_stp || |(evn_ext & ctl.cfg_stp);
  assign evn_trg = ctl.sw_trg || |(evn_ext & ctl.cfg_trg) || (ctl.cfg_edg_en && evn_edg);

  // entry state of an acquisition, skips pre when it is empty
  assign state_go = (ctl.cfg_pre != '0) ? PRE : (ctl.cfg_aut ? POST : ARM);

  // stream gating, idle drains the input
  assign sti.ready = (state == IDLE) || sto.ready;
  assign sto.valid = sti.valid && (state != IDLE);
  assign sto.data  = out_beat_t'{data: sti.data, last: lst};
  assign xfer      = sto.valid && sto.ready;

  // a trigger in arm already makes this cycle's beat a post sample
  assign post_now = (state == POST) || ((state == ARM) && (ctl.cfg_aut || evn_trg));
  assign lst      = post_now && (ctl.sts_pst + CW'(1) == ctl.cfg_pst);
  assign done     = post_now && pst_rch;
  assign cnt_clr  = ctl.ctl_rst || ((state == IDLE) && evn_str) || (done && ctl.cfg_con);

  scope_acq_counter #(.CW (CW)) i_cnt_pre (
    .bus     (bus),
    .rst     (rst),
    .clr     (cnt_clr),
    .inc     (xfer && !post_now),
    .target  (ctl.cfg_pre),
    .count   (ctl.sts_pre),
    .reached (pre_rch)
  );

  scope_acq_counter #(.CW (CW)) i_cnt_pst (
    .bus     (bus),
    .rst     (rst),
    .clr     (cnt_clr),
    .inc     (xfer && post_now),
    .target  (ctl.cfg_pst),
    .count   (ctl.sts_pst),
    .reached (pst_rch)
  );

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  assign ctl.sts_str = (state != IDLE);

  always_ff @(posedge bus) begin
    if (rst || ctl.ctl_rst) begin
      state       <= IDLE;
      ctl.sts_stp <= 1'b0;
      ctl.sts_trg <= 1'b0;
      evn_lst     <= 1'b0;
    end else begin
      evn_lst <= xfer && lst;
      // stop wins over everything
      if (evn_stp) begin
        state       <= IDLE;
        ctl.sts_stp <= 1'b1;
      end else begin
        if (post_now) begin
          ctl.sts_trg <= 1'b1;
        end
        case (state)
          IDLE: if (evn_str) begin
            state       <= state_go;
            ctl.sts_stp <= 1'b0;
            ctl.sts_trg <= (state_go == POST);
          end
          PRE: if (pre_rch) begin
            if (ctl.cfg_aut || evn_trg) begin
              state       <= POST;
              ctl.sts_trg <= 1'b1;
            end else begin
              state <= ARM;
            end
          end
          default: if (done) begin
            state <= ctl.cfg_con ? state_go : IDLE;
          end else if (post_now) begin
            state <= POST;
          end
        endcase
      end
    end
  end

  // post counter and gating together never pass cfg_pst
  a_pst_max: assert property (@(posedge bus) disable iff (rst || ctl.ctl_rst)
    xfer && post_now |-> ctl.sts_pst < ctl.cfg_pst);

endmodule

//--- hw/scope_top.sv
`timescale 1ns/100ps

module scope_top #(
  parameter int unsigned EW  = 4,
  parameter int unsigned CW  = scope_reg_pkg::CNT_W,
  parameter int unsigned DCW = scope_stream_pkg::ACC_DCW,
  parameter int unsigned DSW = 4
) (
  input  logic                             bus,
  input  logic                             rst,
  // register bus
  input  logic                             reg_wen,
  input  logic                             reg_ren,
  input  logic [scope_reg_pkg::BUS_AW-1:0] reg_addr,
  input  logic [scope_reg_pkg::BUS_DW-1:0] reg_wdata,
  output logic [scope_reg_pkg::BUS_DW-1:0] reg_rdata,
  output logic                             reg_ack,
  // ADC samples in
  input  scope_stream_pkg::sample_t        in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  // captured samples out
  output scope_stream_pkg::sample_t        out_data,
  output logic                             out_last,
  output logic                             out_valid,
  input  logic                             out_ready,
  // events
  input  logic [EW-1:0]                    evn_ext,
  output logic                             evn_lst
);

  import scope_stream_pkg::*;

  // decimator and edge config
  logic [DCW-1:0] cfg_dec;
  logic [DSW-1:0] cfg_shr;
  logic           cfg_avg;
  sample_t        cfg_pos;
  sample_t        cfg_neg;
  logic           cfg_edg;
  logic           evn_edg;

  scope_ctl_if #(.EW (EW), .CW (CW)) ctl ();

  // input, decimated and output streams
  sample_stream_if #(.T (sample_t))   sti ();
  sample_stream_if #(.T (sample_t))   std ();
  sample_stream_if #(.T (out_beat_t)) sto ();

  assign sti.data  = in_data;
  assign sti.valid = in_valid;
  assign in_ready  = sti.ready;

  assign out_data  = sto.data.data;
  assign out_last  = sto.data.last;
  assign out_valid = sto.valid;
  assign sto.ready = out_ready;

  scope_regs #(.EW (EW), .CW (CW), .DCW (DCW), .DSW (DSW)) i_regs (
    .bus     (bus),
    .rst     (rst),
    .wen     (reg_wen),
    .ren     (reg_ren),
    .addr    (reg_addr),
    .wdata   (reg_wdata),
    .rdata   (reg_rdata),
    .ack     (reg_ack),
    .ctl     (ctl),
    .cfg_dec (cfg_dec),
    .cfg_shr (cfg_shr),
    .cfg_avg (cfg_avg),
    .cfg_pos (cfg_pos),
    .cfg_neg (cfg_neg),
    .cfg_edg (cfg_edg)
  );

  scope_decimator #(.DCW (DCW), .DSW (DSW)) i_dec (
    .bus     (bus),
    .rst     (rst),
    .ctl_rst (ctl.ctl_rst),
    .cfg_dec (cfg_dec),
    .cfg_shr (cfg_shr),
    .cfg_avg (cfg_avg),
    .sti     (sti),
    .sto     (std)
  );

  scope_edge_trigger i_edge (
    .bus     (bus),
    .rst     (rst),
    .ctl_rst (ctl.ctl_rst),
    .cfg_pos (cfg_pos),
    .cfg_neg (cfg_neg),
    .cfg_edg (cfg_edg),
    .mon     (std),
    .evn_edg (evn_edg)
  );

  scope_acq_fsm #(.EW (EW), .CW (CW)) i_acq (
    .bus     (bus),
    .rst     (rst),
    .ctl     (ctl),
    .evn_ext (evn_ext),
    .evn_edg (evn_edg),
    .sti     (std),
    .sto     (sto),
    .evn_lst (evn_lst)
  );

endmodule

//--- dv/scope_tb_tasks.svh
////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic check_word(input string name, input logic [BUS_DW-1:0] act,
                          input logic [BUS_DW-1:0] exp);
  if (act !== exp) begin
    $display("FAIL %s act 0x%h exp 0x%h", name, act, exp);
    $display("sim failed");
    $fatal(1);
  end
endtask

task automatic check_beat(input string name, input out_beat_t act, input out_beat_t exp);
  if (act !== exp) begin
    $display("FAIL %s act 0x%h exp 0x%h", name, act, exp);
    $display("sim failed");
    $fatal(1);
  end
endtask

task automatic check_flag(input string name, input logic act, input logic exp);
  if (act !== exp) begin
    $display("FAIL %s act 0x%h exp 0x%h", name, act, exp);
    $display("sim failed");
    $fatal(1);
  end
endtask

////////////////////////////////////////////////////////////
// bus and stream drivers
////////////////////////////////////////////////////////////

// ack due one cycle after the access
task automatic reg_write(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] data);
  @(posedge bus);
  reg_wen   <= 1'b1;
  reg_addr  <= addr;
  reg_wdata <= data;
  @(posedge bus);
  reg_wen   <= 1'b0;
  @(negedge bus);
  check_flag("reg_ack", reg_ack, 1'b1);
endtask

task automatic reg_read(input logic [BUS_AW-1:0] addr, output logic [BUS_DW-1:0] data);
  @(posedge bus);
  reg_ren  <= 1'b1;
  reg_addr <= addr;
  @(posedge bus);
  reg_ren  <= 1'b0;
  @(negedge bus);
  check_flag("reg_ack", reg_ack, 1'b1);
  data = reg_rdata;
endtask

task automatic reg_expect(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] exp);
  logic [BUS_DW-1:0] val;
  reg_read(addr, val);
  check_word($sformatf("reg 0x%02h", addr), val, exp);
endtask

// one sample per edge at most, held until taken
task automatic send_samples();
  foreach (tx[i]) begin
    @(posedge bus);
    in_valid <= 1'b1;
    in_data  <= tx[i];
    @(negedge bus);
    while (!in_ready) @(negedge bus);
  end
  @(posedge bus);
  in_valid <= 1'b0;
endtask

// n beats, then a quiet tail so extra beats show up
task automatic wait_beats(input int unsigned n);
  while (got.size() < n) @(negedge bus);
  repeat (6) @(negedge bus);
  check_word("beat count", got.size(), n);
endtask

task automatic pulse_ext(input logic [3:0] val);
  @(posedge bus);
  evn_ext <= val;
  @(posedge bus);
  evn_ext <= '0;
endtask

// configure, clear the datapath, empty the capture
task automatic setup_capture(input int dec, input int shr, input int avg,
                             input int mode, input int pre, input int pst);
  reg_write(REG_DEC, dec);
  reg_write(REG_SHR, shr);
  reg_write(REG_AVG, avg);
  reg_write(REG_MODE, mode);
  reg_write(REG_PRE, pre);
  reg_write(REG_PST, pst);
  reg_write(REG_CTL, 32'h1);
  got.delete();
  tx.delete();
  lst_cnt = 0;
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////

// outputs still at reset values until the first edge without rst
task automatic test_reset_outputs();
  @(negedge bus);
  check_flag("reg_ack", reg_ack, 1'b0);
  check_flag("out_valid", out_valid, 1'b0);
  check_flag("evn_lst", evn_lst, 1'b0);
  check_flag("in_ready", in_ready, 1'b0);
  // input opens one cycle later
  @(negedge bus);
  check_flag("in_ready", in_ready, 1'b1);
endtask

task automatic test_registers();
  logic [BUS_AW-1:0] addrs[15];
  logic [BUS_DW-1:0] masks[15];
  addrs = '{REG_CTL, REG_MODE, REG_MSK_STR, REG_MSK_STP, REG_MSK_TRG, REG_PRE, REG_PST,
            REG_STS_PRE, REG_STS_PST, REG_POS, REG_NEG, REG_EDG, REG_DEC, REG_SHR, REG_AVG};
  masks = '{32'h0, 32'h7, 32'hf, 32'hf, 32'hf, 32'hffffffff, 32'hffffffff,
            32'h0, 32'h0, 32'hffff, 32'hffff, 32'h1, 32'h1ffff, 32'hf, 32'h1};
  foreach (addrs[i]) reg_expect(addrs[i], 32'h0);
  // control register skipped, its writes are pulses
  for (int i = 1; i < 15; i++) begin
    reg_write(addrs[i], 32'hffffffff);
    reg_expect(addrs[i], masks[i]);
    reg_write(addrs[i], 32'h0);
  end
endtask

task automatic test_plain_decimation();
  setup_capture(3, 0, 0, 2, 0, 6);
  reg_write(REG_CTL, 32'h2);
  for (int i = 1; i <= 18; i++) tx.push_back(sample_t'(i));
  send_samples();
  wait_beats(6);
  // every third ramp value, last on the sixth
  for (int k = 0; k < 6; k++) begin
    check_beat("out beat", got[k], out_beat_t'{data: sample_t'(3 * (k + 1)), last: k == 5});
  end
  check_word("evn_lst pulses", lst_cnt, 1);
endtask

task automatic test_averaging();
  longint sum;
  setup_capture(4, 2, 1, 2, 0, 8);
  reg_write(REG_CTL, 32'h2);
  for (int i = 0; i < 32; i++) tx.push_back(sample_t'($random(seed)));
  send_samples();
  wait_beats(8);
  for (int g = 0; g < 8; g++) begin
    sum = 0;
    for (int j = 0; j < 4; j++) sum += longint'(tx[g * 4 + j]);
    check_beat("avg beat", got[g], out_beat_t'{data: sample_t'(sum >>> 2), last: g == 7});
  end
endtask

task automatic test_pre_post_auto();
  setup_capture(1, 0, 0, 2, 5, 7);
  reg_write(REG_CTL, 32'h2);
  for (int i = 0; i < 12; i++) tx.push_back(sample_t'($random(seed)));
  gaps = 1'b1;
  send_samples();
  wait_beats(12);
  gaps = 1'b0;
  foreach (tx[i]) check_beat("pre/post beat", got[i], out_beat_t'{data: tx[i], last: i == 11});
  check_word("evn_lst pulses", lst_cnt, 1);
  reg_expect(REG_STS_PRE, 32'd5);
  reg_expect(REG_STS_PST, 32'd7);
endtask

task automatic test_edge_trigger();
  logic [BUS_DW-1:0] ctl_val;
  // arm at or below 10, fire at or above 50
  setup_capture(1, 0, 0, 4, 0, 4);
  reg_write(REG_NEG, 32'd10);
  reg_write(REG_POS, 32'd50);
  reg_write(REG_EDG, 32'd0);
  reg_write(REG_CTL, 32'h2);
  for (int i = 0; i < 60; i++) tx.push_back(sample_t'(i));
  send_samples();
  // 0..50 before the trigger, 51..54 after
  wait_beats(55);
  for (int k = 0; k < 55; k++) begin
    check_beat("edge beat", got[k], out_beat_t'{data: sample_t'(k), last: k == 54});
  end
  reg_read(REG_CTL, ctl_val);
  check_flag("sts_trg", ctl_val[3], 1'b1);
endtask

task automatic test_stop_external();
  logic [BUS_DW-1:0] ctl_val;
  setup_capture(1, 0, 0, 0, 0, 4);
  reg_write(REG_MSK_STR, 32'h1);
  reg_write(REG_MSK_STP, 32'h2);
  // unmasked bit must not start
  pulse_ext(4'b1000);
  reg_read(REG_CTL, ctl_val);
  check_flag("sts_str", ctl_val[1], 1'b0);
  pulse_ext(4'b0001);
  reg_read(REG_CTL, ctl_val);
  check_flag("sts_str", ctl_val[1], 1'b1);
  pulse_ext(4'b0010);
  reg_read(REG_CTL, ctl_val);
  check_flag("sts_str", ctl_val[1], 1'b0);
  check_flag("sts_stp", ctl_val[2], 1'b1);
  for (int i = 0; i < 8; i++) tx.push_back(sample_t'(100 + i));
  send_samples();
  wait_beats(0);
  check_word("evn_lst pulses", lst_cnt, 0);
endtask

//--- dv/scope_tb.sv
`timescale 1ns/100ps

module scope_tb;

  import scope_stream_pkg::*;
  import scope_reg_pkg::*;

  // samples pushed by all tests together
  localparam int unsigned TEST_SAMPLES    = 18 + 32 + 12 + 60 + 8;
  localparam int unsigned WATCHDOG_CYCLES = TEST_SAMPLES * 20;

  logic              bus;
  logic              rst;
  logic              reg_wen;
  logic              reg_ren;
  logic [BUS_AW-1:0] reg_addr;
  logic [BUS_DW-1:0] reg_wdata;
  logic [BUS_DW-1:0] reg_rdata;
  logic              reg_ack;
  sample_t           in_data;
  logic              in_valid;
  logic              in_ready;
  sample_t           out_data;
  logic              out_last;
  logic              out_valid;
  logic              out_ready;
  logic [3:0]        evn_ext;
  logic              evn_lst;

  // random source and back-pressure control
  integer            seed;
  logic              gaps;

  // captured output beats and last pulses
  out_beat_t         got[$];
  int unsigned       lst_cnt;

  // samples for the next send
  sample_t           tx[$];

  scope_top i_dut (
    .bus       (bus),
    .rst       (rst),
    .reg_wen   (reg_wen),
    .reg_ren   (reg_ren),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .evn_ext   (evn_ext),
    .evn_lst   (evn_lst)
  );

  `include "scope_tb_tasks.svh"

  ////////////////////////////////////////////////////////////
  // clock, back-pressure, output monitor
  ////////////////////////////////////////////////////////////

  always #5 bus = ~bus;

  // roughly one stall cycle in four when gaps are on
  always @(posedge bus) begin
    out_ready <= gaps ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // sampled mid cycle, transfer lands on the next edge
  always @(negedge bus) begin
    if (!rst) begin
      if (out_valid && out_ready) begin
        got.push_back(out_beat_t'{data: out_data, last: out_last});
      end
      if (evn_lst) begin
        lst_cnt++;
      end
    end
  end

  // hard limit on run time
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    bus       = 1'b0;
    rst       = 1'b1;
    reg_wen   = 1'b0;
    reg_ren   = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    evn_ext   = '0;
    gaps      = 1'b0;
    lst_cnt   = 0;
    seed      = 32'h6686a33a;
    repeat (5) @(posedge bus);
    rst <= 1'b0;
    test_reset_outputs();
    test_registers();
    test_plain_decimation();
    test_averaging();
    test_pre_post_auto();
    test_edge_trigger();
    test_stop_external();
    $display("sim passed");
    $finish;
  end

endmodule

//--- src.f
+incdir+dv
hw/scope_stream_pkg.sv
hw/scope_reg_pkg.sv
hw/sample_stream_if.sv
hw/scope_ctl_if.sv
hw/scope_regs.sv
hw/scope_decimator.sv
hw/scope_edge_trigger.sv
hw/scope_acq_counter.sv
hw/scope_acq_fsm.sv
hw/scope_top.sv
dv/scope_tb.sv

//--- Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module scope_top

obj_dir/Vscope_tb: src.f hw/*.sv dv/*.sv dv/*.svh
	verilator --binary --timing --assert -f src.f --top-module scope_tb -Mdir obj_dir

sim: obj_dir/Vscope_tb
	./obj_dir/Vscope_tb | tee /dev/stderr | grep -qx 'sim passed'

clean:
	rm -rf obj_dir
